//--- Makefile
# Verilator build for the instruction cache testbench

TOP := icache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

# pass or fail is decided by the log, not by the simulator exit code
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // width of fetch addresses and of the block address sent to memory
    localparam int ADDR_WIDTH = 32;

    // one instruction, and one beat of a memory burst
    localparam int WORD_WIDTH = 32;

    // byte offset inside a 32-bit word, never used for indexing
    localparam int BYTE_OFFSET_BITS = 2;

    // refill sequencer states
    //   idle     waiting for a miss from the lookup
    //   burst    memory request held, one word written per beat
    //   commit   tag, valid bit and round-robin pointer updated
    //   respond  requested word handed to the data array output
    typedef enum logic [1:0] {
        REFILL_IDLE    = 2'b00,
        REFILL_BURST   = 2'b01,
        REFILL_COMMIT  = 2'b10,
        REFILL_RESPOND = 2'b11
    } refill_state_t;

endpackage : icache_pkg

`default_nettype wire

//--- icache/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_BITS    = $clog2(NUM_SETS),
    localparam int WAY_BITS    = $clog2(NUM_WAYS),
    localparam int OFFSET_BITS = $clog2(BLOCK_WORDS),
    localparam int TAG_BITS    = icache_pkg::ADDR_WIDTH - SET_BITS - OFFSET_BITS
                                 - icache_pkg::BYTE_OFFSET_BITS
) (
    input  wire logic                              Clk,
    input  wire logic                              rst_n,
    // core fetch side
    input  wire logic                              read_enable,
    input  wire logic [icache_pkg::ADDR_WIDTH-1:0] read_address,
    output logic [icache_pkg::WORD_WIDTH-1:0]      instruction,
    output logic                                   ready,
    output logic                                   busy,
    // SDRAM controller side
    input  wire logic [icache_pkg::WORD_WIDTH-1:0] mem_data_in,
    input  wire logic                              mem_data_ready,
    output logic [icache_pkg::ADDR_WIDTH-1:0]      mem_read_address,
    output logic                                   mem_read_request
);

    // lookup results for the current request
    logic                   lookup_hit;
    logic                   lookup_miss;
    logic [WAY_BITS-1:0]    hit_way;
    logic [SET_BITS-1:0]    req_set;
    logic [TAG_BITS-1:0]    req_tag;
    logic [OFFSET_BITS-1:0] req_offset;
    logic [WAY_BITS-1:0]    victim_way;

    // refill traffic into the tag and data storage
    logic                              fill_write;
    logic [SET_BITS-1:0]               fill_set;
    logic [WAY_BITS-1:0]               fill_way;
    logic [OFFSET_BITS-1:0]            fill_word_index;
    logic [icache_pkg::WORD_WIDTH-1:0] fill_data;
    logic                              fill_commit;
    logic [TAG_BITS-1:0]               fill_tag;
    logic                              fill_done;
    logic [OFFSET_BITS-1:0]            fill_offset;

    icache_tag_lookup #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_tag_lookup (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .read_enable  (read_enable),
        .read_address (read_address),
        .busy         (busy),
        .fill_commit  (fill_commit),
        .fill_set     (fill_set),
        .fill_way     (fill_way),
        .fill_tag     (fill_tag),
        .lookup_hit   (lookup_hit),
        .lookup_miss  (lookup_miss),
        .hit_way      (hit_way),
        .req_set      (req_set),
        .req_tag      (req_tag),
        .req_offset   (req_offset),
        .victim_way   (victim_way)
    );

    icache_refill #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_refill (
        .Clk              (Clk),
        .rst_n            (rst_n),
        .lookup_miss      (lookup_miss),
        .req_set          (req_set),
        .req_tag          (req_tag),
        .req_offset       (req_offset),
        .victim_way       (victim_way),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .busy             (busy),
        .fill_write       (fill_write),
        .fill_set         (fill_set),
        .fill_way         (fill_way),
        .fill_word_index  (fill_word_index),
        .fill_data        (fill_data),
        .fill_commit      (fill_commit),
        .fill_tag         (fill_tag),
        .fill_done        (fill_done),
        .fill_offset      (fill_offset)
    );

    icache_data_array #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_data_array (
        .Clk             (Clk),
        .rst_n           (rst_n),
        .lookup_hit      (lookup_hit),
        .hit_way         (hit_way),
        .req_set         (req_set),
        .req_offset      (req_offset),
        .fill_write      (fill_write),
        .fill_set        (fill_set),
        .fill_way        (fill_way),
        .fill_word_index (fill_word_index),
        .fill_data       (fill_data),
        .fill_done       (fill_done),
        .fill_offset     (fill_offset),
        .instruction     (instruction),
        .ready           (ready)
    );

endmodule : icache

`default_nettype wire

//--- icache/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_array #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_BITS    = $clog2(NUM_SETS),
    localparam int WAY_BITS    = $clog2(NUM_WAYS),
    localparam int OFFSET_BITS = $clog2(BLOCK_WORDS)
) (
    input  wire logic                              Clk,
    input  wire logic                              rst_n,
    input  wire logic                              lookup_hit,
    input  wire logic [WAY_BITS-1:0]               hit_way,
    input  wire logic [SET_BITS-1:0]               req_set,
    input  wire logic [OFFSET_BITS-1:0]            req_offset,
    input  wire logic                              fill_write,
    input  wire logic [SET_BITS-1:0]               fill_set,
    input  wire logic [WAY_BITS-1:0]               fill_way,
    input  wire logic [OFFSET_BITS-1:0]            fill_word_index,
    input  wire logic [icache_pkg::WORD_WIDTH-1:0] fill_data,
    input  wire logic                              fill_done,
    input  wire logic [OFFSET_BITS-1:0]            fill_offset,
    output logic [icache_pkg::WORD_WIDTH-1:0]      instruction,
    output logic                                   ready
);

    // one word slot per set, way and block position
    logic [icache_pkg::WORD_WIDTH-1:0] block_mem [NUM_SETS][NUM_WAYS][BLOCK_WORDS];

    always_ff @(posedge Clk) begin
        if (fill_write) begin
            block_mem[fill_set][fill_way][fill_word_index] <= fill_data;
        end
    end

    // hits and fill responses never coincide, the lookup is blocked while busy
    always_ff @(posedge Clk) begin
        if (lookup_hit) begin
            instruction <= block_mem[req_set][hit_way][req_offset];
        end else if (fill_done) begin
            instruction <= block_mem[fill_set][fill_way][fill_offset];
        end
    end

    // single-cycle strobe that goes with the word above
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= lookup_hit || fill_done;
        end
    end

endmodule : icache_data_array

`default_nettype wire

//--- icache/icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_BITS    = $clog2(NUM_SETS),
    localparam int WAY_BITS    = $clog2(NUM_WAYS),
    localparam int OFFSET_BITS = $clog2(BLOCK_WORDS),
    localparam int TAG_BITS    = icache_pkg::ADDR_WIDTH - SET_BITS - OFFSET_BITS
                                 - icache_pkg::BYTE_OFFSET_BITS
) (
    input  wire logic                              Clk,
    input  wire logic                              rst_n,
    input  wire logic                              lookup_miss,
    input  wire logic [SET_BITS-1:0]               req_set,
    input  wire logic [TAG_BITS-1:0]               req_tag,
    input  wire logic [OFFSET_BITS-1:0]            req_offset,
    input  wire logic [WAY_BITS-1:0]               victim_way,
    input  wire logic [icache_pkg::WORD_WIDTH-1:0] mem_data_in,
    input  wire logic                              mem_data_ready,
    output logic [icache_pkg::ADDR_WIDTH-1:0]      mem_read_address,
    output logic                                   mem_read_request,
    output logic                                   busy,
    output logic                                   fill_write,
    output logic [SET_BITS-1:0]                    fill_set,
    output logic [WAY_BITS-1:0]                    fill_way,
    output logic [OFFSET_BITS-1:0]                 fill_word_index,
    output logic [icache_pkg::WORD_WIDTH-1:0]      fill_data,
    output logic                                   fill_commit,
    output logic [TAG_BITS-1:0]                    fill_tag,
    output logic                                   fill_done,
    output logic [OFFSET_BITS-1:0]                 fill_offset
);

    import icache_pkg::*;

    refill_state_t state;

    // beat counter, also the word index of the next incoming beat
    logic [OFFSET_BITS-1:0] beat_count;
    logic                   last_beat;

    // miss context, captured once and held for the whole refill
    logic [SET_BITS-1:0]    miss_set;
    logic [TAG_BITS-1:0]    miss_tag;
    logic [OFFSET_BITS-1:0] miss_offset;
    logic [WAY_BITS-1:0]    miss_way;

    assign last_beat = mem_data_ready && (beat_count == OFFSET_BITS'(BLOCK_WORDS - 1));

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state      <= REFILL_IDLE;
            beat_count <= '0;
        end else begin
            case (state)
                REFILL_IDLE: begin
                    beat_count <= '0;
                    if (lookup_miss) begin
                        state <= REFILL_BURST;
                    end
                end
                REFILL_BURST: begin
                    // gaps between beats simply stall here
                    if (mem_data_ready) begin
                        beat_count <= beat_count + 1'b1;
                    end
                    if (last_beat) begin
                        state <= REFILL_COMMIT;
                    end
                end
                REFILL_COMMIT: begin
                    state <= REFILL_RESPOND;
                end
                REFILL_RESPOND: begin
                    state <= REFILL_IDLE;
                end
                default: begin
                    state <= REFILL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if ((state == REFILL_IDLE) && lookup_miss) begin
            miss_set    <= req_set;
            miss_tag    <= req_tag;
            miss_offset <= req_offset;
            miss_way    <= victim_way;
        end
    end

    // block-aligned burst address, stable while the request is up
    assign mem_read_address = {miss_tag, miss_set,
                               {(OFFSET_BITS + BYTE_OFFSET_BITS){1'b0}}};
    assign mem_read_request = (state == REFILL_BURST);
    assign busy             = (state != REFILL_IDLE);

    // each beat goes straight into the victim way
    assign fill_write      = (state == REFILL_BURST) && mem_data_ready;
    assign fill_word_index = beat_count;
    assign fill_data       = mem_data_in;
    assign fill_set        = miss_set;
    assign fill_way        = miss_way;
    assign fill_tag        = miss_tag;
    assign fill_offset     = miss_offset;

    assign fill_commit = (state == REFILL_COMMIT);
    assign fill_done   = (state == REFILL_RESPOND);

endmodule : icache_refill

`default_nettype wire

//--- icache/icache_tag_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_lookup #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_BITS    = $clog2(NUM_SETS),
    localparam int WAY_BITS    = $clog2(NUM_WAYS),
    localparam int OFFSET_BITS = $clog2(BLOCK_WORDS),
    localparam int TAG_BITS    = icache_pkg::ADDR_WIDTH - SET_BITS - OFFSET_BITS
                                 - icache_pkg::BYTE_OFFSET_BITS
) (
    input  wire logic                              Clk,
    input  wire logic                              rst_n,
    input  wire logic                              read_enable,
    input  wire logic [icache_pkg::ADDR_WIDTH-1:0] read_address,
    input  wire logic                              busy,
    input  wire logic                              fill_commit,
    input  wire logic [SET_BITS-1:0]               fill_set,
    input  wire logic [WAY_BITS-1:0]               fill_way,
    input  wire logic [TAG_BITS-1:0]               fill_tag,
    output logic                                   lookup_hit,
    output logic                                   lookup_miss,
    output logic [WAY_BITS-1:0]                    hit_way,
    output logic [SET_BITS-1:0]                    req_set,
    output logic [TAG_BITS-1:0]                    req_tag,
    output logic [OFFSET_BITS-1:0]                 req_offset,
    output logic [WAY_BITS-1:0]                    victim_way
);

    import icache_pkg::*;

    // per set: one valid bit per way, one tag per way, one replacement pointer
    logic [NUM_WAYS-1:0] valid_bits [NUM_SETS];
    logic [TAG_BITS-1:0] tag_mem    [NUM_SETS][NUM_WAYS];
    logic [WAY_BITS-1:0] rr_ptr     [NUM_SETS];

    logic                accepted;
    logic                any_match;
    logic [WAY_BITS-1:0] match_way;
    logic                any_invalid;
    logic [WAY_BITS-1:0] free_way;

    // address layout: tag | set | word offset | byte offset
    assign req_tag    = read_address[ADDR_WIDTH-1 -: TAG_BITS];
    assign req_set    = read_address[BYTE_OFFSET_BITS + OFFSET_BITS +: SET_BITS];
    assign req_offset = read_address[BYTE_OFFSET_BITS +: OFFSET_BITS];

    // all ways of the set compared at once
    // walking down from the top way leaves the lowest index in free_way
    always_comb begin
        any_match   = 1'b0;
        match_way   = '0;
        any_invalid = 1'b0;
        free_way    = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (valid_bits[req_set][w] && (tag_mem[req_set][w] == req_tag)) begin
                any_match = 1'b1;
                match_way = WAY_BITS'(w);
            end
            if (!valid_bits[req_set][w]) begin
                any_invalid = 1'b1;
                free_way    = WAY_BITS'(w);
            end
        end
    end

    // requests arriving during a refill are dropped here
    assign accepted    = read_enable && !busy;
    assign lookup_hit  = accepted && any_match;
    assign lookup_miss = accepted && !any_match;
    assign hit_way     = match_way;

    // empty ways are filled before anything gets evicted
    assign victim_way = any_invalid ? free_way : rr_ptr[req_set];

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_bits[s] <= '0;
                rr_ptr[s]     <= '0;
            end
        end else if (fill_commit) begin
            valid_bits[fill_set][fill_way] <= 1'b1;
            // pointer moves on every fill, even into an empty way
            rr_ptr[fill_set] <= rr_ptr[fill_set] + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fill_commit) begin
            tag_mem[fill_set][fill_way] <= fill_tag;
        end
    end

endmodule : icache_tag_lookup

`default_nettype wire

//--- tb.f
common/icache_pkg.sv
icache/icache_tag_lookup.sv
icache/icache_refill.sv
icache/icache_data_array.sv
icache/icache.sv
testbench/icache_mem_model.sv
testbench/icache_asserts.sv
testbench/icache_tb.sv

//--- testbench/icache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module icache_asserts (
    input wire logic                              Clk,
    input wire logic                              rst_n,
    input wire icache_pkg::refill_state_t         state,
    input wire logic                              lookup_miss,
    input wire logic                              last_beat,
    input wire logic                              mem_read_request,
    input wire logic [icache_pkg::ADDR_WIDTH-1:0] mem_read_address,
    input wire logic                              busy,
    input wire logic                              fill_done
);

    import icache_pkg::*;

    // request and block address stay put until the last beat is taken
    a_request_held: assert property (@(posedge Clk) disable iff (!rst_n)
        mem_read_request && !last_beat |=> mem_read_request && $stable(mem_read_address))
        else $error("memory request or address changed before the last beat");

    a_request_drops: assert property (@(posedge Clk) disable iff (!rst_n)
        last_beat |=> !mem_read_request)
        else $error("memory request still high after the last beat");

    // a miss takes the refill out of idle on the next edge
    a_miss_starts_burst: assert property (@(posedge Clk) disable iff (!rst_n)
        lookup_miss |=> (state == REFILL_BURST) && busy)
        else $error("miss did not start a burst with busy high");

    // the cycle after fill_done carries ready, so it must be single and not busy
    a_ready_pulse: assert property (@(posedge Clk) disable iff (!rst_n)
        fill_done |=> !fill_done && !busy)
        else $error("refill response longer than one cycle or busy with ready");

endmodule : icache_asserts

bind icache_refill icache_asserts u_asserts (
    .Clk              (Clk),
    .rst_n            (rst_n),
    .state            (state),
    .lookup_miss      (lookup_miss),
    .last_beat        (last_beat),
    .mem_read_request (mem_read_request),
    .mem_read_address (mem_read_address),
    .busy             (busy),
    .fill_done        (fill_done)
);

`default_nettype wire

//--- testbench/icache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model #(
    parameter int BLOCK_WORDS = 4,
    parameter int SEED        = 25230
) (
    input  wire logic                              Clk,
    input  wire logic                              rst_n,
    input  wire logic                              mem_read_request,
    input  wire logic [icache_pkg::ADDR_WIDTH-1:0] mem_read_address,
    output logic [icache_pkg::WORD_WIDTH-1:0]      mem_data_in,
    output logic                                   mem_data_ready
);

    import icache_pkg::*;

    int seed;
    int beats_sent;

    // memory contents: the byte address mixed with a constant
    function automatic logic [WORD_WIDTH-1:0] word_at(input logic [ADDR_WIDTH-1:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5EED_C0DE;
    endfunction

    // one beat per falling edge at most, idle gaps drawn at random
    initial begin
        seed           = SEED;
        beats_sent     = 0;
        mem_data_in    = '0;
        mem_data_ready = 1'b0;
        forever begin
            @(negedge Clk);
            mem_data_ready = 1'b0;
            if (!rst_n || !mem_read_request) begin
                beats_sent = 0;
            end else if ((beats_sent < BLOCK_WORDS) && (($random(seed) & 3) != 0)) begin
                mem_data_in    = word_at(mem_read_address + ADDR_WIDTH'(beats_sent * 4));
                mem_data_ready = 1'b1;
                beats_sent++;
            end
        end
    end

endmodule : icache_mem_model

`default_nettype wire

//--- testbench/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    import icache_pkg::*;

    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;
    localparam int SET_BITS    = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = $clog2(BLOCK_WORDS);
    localparam int WAIT_LIMIT  = 200;
    localparam int NUM_FETCHES = 400;

    logic                  Clk;
    logic                  rst_n;
    logic                  read_enable;
    logic [ADDR_WIDTH-1:0] read_address;
    logic [WORD_WIDTH-1:0] instruction;
    logic                  ready;
    logic                  busy;
    logic [WORD_WIDTH-1:0] mem_data_in;
    logic                  mem_data_ready;
    logic [ADDR_WIDTH-1:0] mem_read_address;
    logic                  mem_read_request;

    int    seed;
    string test_name;

    // reference copy of tags, valid bits and replacement pointers
    logic                  model_valid [NUM_SETS][NUM_WAYS];
    logic [ADDR_WIDTH-1:0] model_tag   [NUM_SETS][NUM_WAYS];
    int                    model_ptr   [NUM_SETS];

    icache #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) UUT (
        .Clk              (Clk),
        .rst_n            (rst_n),
        .read_enable      (read_enable),
        .read_address     (read_address),
        .instruction      (instruction),
        .ready            (ready),
        .busy             (busy),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request)
    );

    icache_mem_model #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .SEED        (25230)
    ) u_mem (
        .Clk              (Clk),
        .rst_n            (rst_n),
        .mem_read_request (mem_read_request),
        .mem_read_address (mem_read_address),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_instruction(input string name, input logic [WORD_WIDTH-1:0] exp,
                                     input logic [WORD_WIDTH-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED %s %s expected %h actual %h",
                               test_name, name, exp, act));
        end
    endtask

    task automatic check_hit_miss(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED %s %s expected hit=%b actual hit=%b",
                               test_name, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED %s %s expected %b actual %b",
                               test_name, name, exp, act));
        end
    endtask

    task automatic check_address(input string name, input logic [ADDR_WIDTH-1:0] exp,
                                 input logic [ADDR_WIDTH-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED %s %s expected %h actual %h",
                               test_name, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_run($sformatf("CHECK FAILED %s %s expected %0d actual %0d",
                               test_name, name, exp, act));
        end
    endtask

    function automatic logic [WORD_WIDTH-1:0] expected_word(input logic [ADDR_WIDTH-1:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5EED_C0DE;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] make_address(input int tag, input int set,
                                                           input int offset);
        return (ADDR_WIDTH'(tag) << (BYTE_OFFSET_BITS + OFFSET_BITS + SET_BITS))
             | (ADDR_WIDTH'(set) << (BYTE_OFFSET_BITS + OFFSET_BITS))
             | (ADDR_WIDTH'(offset) << BYTE_OFFSET_BITS);
    endfunction

    // two more tags per set than ways, so blocks get evicted
    function automatic logic [ADDR_WIDTH-1:0] random_address();
        int tag;
        int set;
        int offset;
        tag    = 32 + int'($unsigned($random(seed)) % (NUM_WAYS + 2));
        set    = int'($unsigned($random(seed)) % NUM_SETS);
        offset = int'($unsigned($random(seed)) % BLOCK_WORDS);
        return make_address(tag, set, offset);
    endfunction

    // returns the expected hit, and on a miss installs the block like the cache should
    function automatic logic model_access(input logic [ADDR_WIDTH-1:0] addr);
        int                    set;
        int                    way;
        logic [ADDR_WIDTH-1:0] block_tag;
        set       = int'((addr >> (BYTE_OFFSET_BITS + OFFSET_BITS)) % NUM_SETS);
        block_tag = addr >> (BYTE_OFFSET_BITS + OFFSET_BITS + SET_BITS);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[set][w] && (model_tag[set][w] == block_tag)) begin
                return 1'b1;
            end
        end
        // lowest invalid way wins, else the round-robin pointer
        way = model_ptr[set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!model_valid[set][w]) begin
                way = w;
            end
        end
        model_valid[set][way] = 1'b1;
        model_tag[set][way]   = block_tag;
        model_ptr[set]        = (model_ptr[set] + 1) % NUM_WAYS;
        return 1'b0;
    endfunction

    task automatic fetch(input logic [ADDR_WIDTH-1:0] addr);
        logic exp_hit;
        int   edges;
        int   last_edge;
        int   beats;
        int   gap;
        exp_hit      = model_access(addr);
        read_enable  = 1'b1;
        read_address = addr;
        @(posedge Clk);
        @(negedge Clk);
        read_enable = 1'b0;
        check_hit_miss("lookup result", exp_hit, ready);
        if (exp_hit) begin
            check_flag("no memory request on a hit", 1'b0, mem_read_request);
        end else begin
            check_flag("memory request on a miss", 1'b1, mem_read_request);
            check_address("burst address", addr & ~ADDR_WIDTH'(BLOCK_WORDS * 4 - 1),
                          mem_read_address);
            edges     = 0;
            last_edge = 0;
            beats     = 0;
            while (!ready) begin
                check_flag("busy during refill", 1'b1, busy);
                if (edges >= WAIT_LIMIT) begin
                    stop_run("timeout: ready never rose after a cache miss");
                end
                // stray requests while busy get dropped by the cache
                read_enable  = ($random(seed) & 1) != 0;
                read_address = random_address();
                @(posedge Clk);
                edges++;
                if (mem_data_ready) begin
                    beats++;
                    last_edge = edges;
                end
                @(negedge Clk);
                read_enable = 1'b0;
            end
            check_flag("busy low with ready", 1'b0, busy);
            check_count("beats per burst", BLOCK_WORDS, beats);
            check_count("edges from last beat to ready", 2, edges - last_edge);
        end
        check_instruction("fetched word", expected_word(addr), instruction);
        gap = 1 + int'($unsigned($random(seed)) % 3);
        repeat (gap) begin
            @(posedge Clk);
            @(negedge Clk);
            check_flag("single ready pulse", 1'b0, ready);
            check_flag("no stray memory request", 1'b0, mem_read_request);
        end
    endtask

    initial begin
        seed         = 25230;
        rst_n        = 1'b0;
        read_enable  = 1'b0;
        read_address = '0;
        test_name    = "reset";
        for (int s = 0; s < NUM_SETS; s++) begin
            model_ptr[s] = 0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (10) @(negedge Clk);
        rst_n = 1'b1;
        @(negedge Clk);
        check_flag("ready after reset", 1'b0, ready);
        check_flag("busy after reset", 1'b0, busy);
        check_flag("request after reset", 1'b0, mem_read_request);

        // one more tag than ways in set 3, the oldest block must miss again
        test_name = "eviction";
        for (int t = 0; t <= NUM_WAYS; t++) begin
            fetch(make_address(100 + t, 3, t % BLOCK_WORDS));
        end
        fetch(make_address(100, 3, 2));
        fetch(make_address(100 + NUM_WAYS, 3, 1));

        test_name = "random fetches";
        repeat (NUM_FETCHES) begin
            fetch(random_address());
        end
        $display("Test OK");
        $finish;
    end

endmodule : icache_tb

`default_nettype wire
